// File: filelist.f
rtl/dpath_pkg.sv
rtl/fetch_stage.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/core_dpath.sv
verification/tb_core_dpath.sv

// File: verification/tb_core_dpath.sv
// Testbench for core_dpath. It acts as the controller and drives each select in its stage.
// Loads write no register, so a bypass never needs a load value from X.

`timescale 1ns/10ps
`default_nettype none

module tb_core_dpath import dpath_pkg::*; ();

  localparam int MAX_CYCLES = 2000;

  logic clk = 1'b0;
  logic reset, stall, rf_wen;
  pc_sel_e pc_sel;
  logic [XLEN-1:0] inst_d, dmem_rdata;
  byp_sel_e rdata0_byp_sel, rdata1_byp_sel;
  op0_sel_e op0_sel;
  op1_sel_e op1_sel;
  alu_fn_e alu_fn;
  load_sel_e load_sel;
  wb_sel_e wb_sel;
  logic [RADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0] imem_addr, dmem_addr, dmem_wdata, wb_data;
  logic eq, ne, lt, ltu, ge, geu;

  core_dpath uut (
    .clk, .reset, .stall, .pc_sel, .inst_d, .rdata0_byp_sel, .rdata1_byp_sel,
    .op0_sel, .op1_sel, .alu_fn, .dmem_rdata, .load_sel, .wb_sel, .rf_wen, .rf_waddr,
    .imem_addr, .dmem_addr, .dmem_wdata,
    .branch_cond_eq (eq), .branch_cond_ne (ne), .branch_cond_lt (lt),
    .branch_cond_ltu (ltu), .branch_cond_ge (ge), .branch_cond_geu (geu),
    .wb_data
  );

  always #4 clk = ~clk;

  // Program-order register model and expected PCs
  logic [XLEN-1:0] mregs [NREGS];
  logic [XLEN-1:0] pc_f_m, pc_d_m;
  int seed = 32'h8372;
  int cycles = 0;

  // In-flight items while an item issues: 0 is D, 1 is X, 2 is M, 3 is W
  logic      st_valid [4];
  alu_fn_e   st_fn [4];
  load_sel_e st_ls [4];
  wb_sel_e   st_ws [4];
  logic      st_wen [4];
  logic [4:0] st_rd [4];
  logic [XLEN-1:0] st_rdata [4], st_alu [4], st_res [4], st_op0 [4], st_op1 [4], st_rs2v [4];

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("test failed");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [XLEN-1:0] ref_alu(input alu_fn_e fn, input logic [XLEN-1:0] a,
      input logic [XLEN-1:0] b);
    case (fn)
      ALU_ADD:    return a + b;
      ALU_SUB:    return a - b;
      ALU_SLL:    return a << b[4:0];
      ALU_SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU:   return (a < b) ? 32'd1 : 32'd0;
      ALU_XOR:    return a ^ b;
      ALU_SRL:    return a >> b[4:0];
      ALU_SRA:    return $unsigned($signed(a) >>> b[4:0]);
      ALU_OR:     return a | b;
      ALU_AND:    return a & b;
      ALU_CP_OP0: return a;
      default:    return b;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] extend_load(input load_sel_e ls,
      input logic [XLEN-1:0] d);
    case (ls)
      LD_B:    return {{24{d[7]}}, d[7:0]};
      LD_BU:   return {24'b0, d[7:0]};
      LD_H:    return {{16{d[15]}}, d[15:0]};
      LD_HU:   return {16'b0, d[15:0]};
      default: return d;
    endcase
  endfunction

  // Order is eq, ne, lt, ltu, ge, geu
  function automatic logic [5:0] compare_flags(input logic [XLEN-1:0] a,
      input logic [XLEN-1:0] b);
    logic slt, ult;
    slt = $signed(a) < $signed(b);
    ult = a < b;
    return {a == b, a != b, slt, ult, !slt, !ult};
  endfunction

  // Youngest in-flight writer of a register wins
  function automatic byp_sel_e pick_byp(input logic [4:0] r);
    if (r == 5'd0) return BYP_RF;
    if (st_valid[1] && st_wen[1] && st_rd[1] == r) return BYP_X;
    if (st_valid[2] && st_wen[2] && st_rd[2] == r) return BYP_M;
    if (st_valid[3] && st_wen[3] && st_rd[3] == r) return BYP_W;
    return BYP_RF;
  endfunction

  task automatic check(input logic [XLEN-1:0] act, input logic [XLEN-1:0] exp, input string what);
    if (act !== exp) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, act, exp);
      $display("test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Item at index x sits in X, the ones behind it in M and W
  task automatic drive_late_stages(input int x);
    alu_fn     = st_fn[x];
    load_sel   = st_ls[x+1];
    wb_sel     = st_ws[x+1];
    dmem_rdata = st_rdata[x+1];
    rf_wen     = st_valid[x+2] && st_wen[x+2];
    rf_waddr   = st_rd[x+2];
  endtask

  task automatic check_outputs(input int x);
    if (st_valid[x]) begin
      check(dmem_addr, st_alu[x], "dmem_addr");
      check(dmem_wdata, st_rs2v[x], "dmem_wdata");
      check({26'b0, eq, ne, lt, ltu, ge, geu}, {26'b0, compare_flags(st_op0[x], st_op1[x])},
            "branch flags");
    end
    if (st_valid[x+2]) check(wb_data, st_res[x+2], "wb_data");
  endtask

  // Called on a falling edge; returns on the next falling edge
  task automatic issue(input logic [XLEN-1:0] inst, input op0_sel_e o0, input op1_sel_e o1,
      input alu_fn_e fn, input pc_sel_e ps, input load_sel_e ls, input wb_sel_e ws,
      input logic [XLEN-1:0] rdata, input logic wen, input logic [4:0] rd);
    logic [XLEN-1:0] rs1v, rs2v, a, b, alu, res, nxt, imm_i, imm_uj;
    int k;
    for (k = 3; k > 0; k--) begin
      st_valid[k] = st_valid[k-1];
      st_fn[k]    = st_fn[k-1];
      st_ls[k]    = st_ls[k-1];
      st_ws[k]    = st_ws[k-1];
      st_wen[k]   = st_wen[k-1];
      st_rd[k]    = st_rd[k-1];
      st_rdata[k] = st_rdata[k-1];
      st_alu[k]   = st_alu[k-1];
      st_res[k]   = st_res[k-1];
      st_op0[k]   = st_op0[k-1];
      st_op1[k]   = st_op1[k-1];
      st_rs2v[k]  = st_rs2v[k-1];
    end
    imm_i  = {{20{inst[31]}}, inst[31:20]};
    imm_uj = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    rs1v = mregs[inst[19:15]];
    rs2v = mregs[inst[24:20]];
    rdata0_byp_sel = pick_byp(inst[19:15]);
    rdata1_byp_sel = pick_byp(inst[24:20]);
    case (o0)
      OP0_RS1:      a = rs1v;
      OP0_PC:       a = pc_d_m;
      OP0_PC_PLUS4: a = pc_d_m + 32'd4;
      default:      a = '0;
    endcase
    case (o1)
      OP1_RS2:    b = rs2v;
      OP1_SHAMT:  b = {27'b0, inst[24:20]};
      OP1_IMM_U:  b = {inst[31:12], 12'b0};
      OP1_IMM_SB: b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      OP1_IMM_I:  b = imm_i;
      OP1_IMM_S:  b = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      default:    b = '0;
    endcase
    alu = ref_alu(fn, a, b);
    res = (ws == WB_MEM) ? extend_load(ls, rdata) : alu;
    case (ps)
      PC_JUMP:    nxt = pc_d_m + imm_uj;
      PC_JUMPREG: nxt = (rs1v + imm_i) & ~32'd1;
      default:    nxt = pc_f_m + 32'd4;
    endcase
    if (wen && rd != 5'd0) mregs[rd] = res;
    st_valid[0] = 1'b1;
    st_fn[0]    = fn;
    st_ls[0]    = ls;
    st_ws[0]    = ws;
    st_wen[0]   = wen;
    st_rd[0]    = rd;
    st_rdata[0] = rdata;
    st_alu[0]   = alu;
    st_res[0]   = res;
    st_op0[0]   = a;
    st_op1[0]   = b;
    st_rs2v[0]  = rs2v;
    inst_d   = inst;
    op0_sel  = o0;
    op1_sel  = o1;
    pc_sel   = ps;
    drive_late_stages(1);
    #1;
    check(imem_addr, nxt, "imem_addr");
    check_outputs(1);
    @(posedge clk);
    pc_d_m = pc_f_m;
    pc_f_m = nxt;
    @(negedge clk);
  endtask

  // Frozen pipeline keeps the last issued item in X
  task automatic hold_stall(input int n);
    logic [XLEN-1:0] held;
    held = pc_f_m + 32'd4;
    stall  = 1'b1;
    pc_sel = PC_PLUS4;
    drive_late_stages(0);
    repeat (n) begin
      #1;
      check(imem_addr, held, "imem_addr under stall");
      check_outputs(0);
      @(posedge clk);
      @(negedge clk);
    end
    stall = 1'b0;
  endtask

  task automatic bubble();
    issue('0, OP0_ZERO, OP1_ZERO, ALU_ADD, PC_PLUS4, LD_W, WB_EXE, '0, 1'b0, 5'd0);
  endtask

  initial begin
    int i;
    logic [XLEN-1:0] r;
    logic [4:0] s1, s2, rd, p1, p2, p3;
    reset = 1'b1;
    stall = 1'b0;
    pc_sel = PC_PLUS4;
    inst_d = '0;
    rdata0_byp_sel = BYP_RF;
    rdata1_byp_sel = BYP_RF;
    op0_sel = OP0_ZERO;
    op1_sel = OP1_ZERO;
    alu_fn = ALU_ADD;
    dmem_rdata = '0;
    load_sel = LD_W;
    wb_sel = WB_EXE;
    rf_wen = 1'b0;
    rf_waddr = '0;
    for (i = 0; i < NREGS; i++) mregs[i] = '0;
    for (i = 0; i < 4; i++) begin
      st_valid[i] = 1'b0;
      st_fn[i]    = ALU_ADD;
      st_ls[i]    = LD_W;
      st_ws[i]    = WB_EXE;
      st_wen[i]   = 1'b0;
      st_rd[i]    = '0;
      st_rdata[i] = '0;
    end

    repeat (3) begin
      @(negedge clk);
      check(imem_addr, RESET_VECTOR, "imem_addr in reset");
    end
    reset = 1'b0;
    pc_f_m = RESET_VECTOR;
    pc_d_m = RESET_VECTOR;

    // ------------------------------------------------------------
    // Register constants, x5 kept word aligned for jump-register
    // ------------------------------------------------------------
    for (i = 1; i < NREGS; i++) begin
      r = $random(seed);
      if (i == 5) r[21:20] = 2'b00;
      issue({r[31:20], 5'd0, 15'b0}, OP0_ZERO, OP1_IMM_I, ALU_ADD, PC_PLUS4, LD_W, WB_EXE,
            '0, 1'b1, 5'(i));
    end

    // Every ALU function on random registers and immediates
    for (i = 0; i < 60; i++) begin
      r = $random(seed);
      s1 = (r[4:0] == 0) ? 5'd1 : r[4:0];
      s2 = r[9:5];
      rd = (r[14:10] == 0 || r[14:10] == 5) ? 5'd6 : r[14:10];
      issue({r[31:25], s2, s1, 15'b0}, (i % 5 == 4) ? OP0_PC : OP0_RS1,
            op1_sel_e'((i % 4 == 3) ? 2 : ((i % 4 == 2) ? 1 : ((i % 4 == 1) ? 4 : 0))),
            alu_fn_e'(i % 12), PC_PLUS4, LD_W, WB_EXE, '0, 1'b1, rd);
    end

    // Dependent chain through X, M and W
    p1 = 5'd7;
    p2 = 5'd8;
    p3 = 5'd9;
    for (i = 0; i < 12; i++) begin
      rd = 5'd10 + 5'(i % 4);
      issue({7'd0, (i % 2) ? p3 : p2, p1, 15'b0}, OP0_RS1, OP1_RS2,
            (i % 2) ? ALU_XOR : ALU_ADD, PC_PLUS4, LD_W, WB_EXE, '0, 1'b1, rd);
      p3 = p2;
      p2 = p1;
      p1 = rd;
    end

    // Branch flags on random and equal operands
    for (i = 0; i < 10; i++) begin
      r = $random(seed);
      s1 = r[4:0];
      s2 = (i % 2) ? s1 : r[9:5];
      issue({7'd0, s2, s1, 15'b0}, OP0_RS1, OP1_RS2, ALU_SUB, PC_PLUS4, LD_W, WB_EXE,
            '0, 1'b0, 5'd0);
    end

    // Stall freezes the PC and every stage
    issue({7'd0, 5'd3, 5'd2, 15'b0}, OP0_RS1, OP1_RS2, ALU_ADD, PC_PLUS4, LD_W, WB_EXE,
          '0, 1'b1, 5'd20);
    issue({7'd0, 5'd20, 5'd4, 15'b0}, OP0_RS1, OP1_RS2, ALU_OR, PC_PLUS4, LD_W, WB_EXE,
          '0, 1'b1, 5'd21);
    hold_stall(3);
    issue({7'd0, 5'd21, 5'd20, 15'b0}, OP0_RS1, OP1_RS2, ALU_SUB, PC_PLUS4, LD_W, WB_EXE,
          '0, 1'b1, 5'd22);

    // Jumps and jump-register with rs1 bypassed from X
    for (i = 0; i < 4; i++) begin
      r = $random(seed);
      issue({r[31:22], 2'b00, 5'd0, 15'b0}, OP0_ZERO, OP1_IMM_I, ALU_ADD, PC_PLUS4, LD_W,
            WB_EXE, '0, 1'b1, 5'd5);
      r = $random(seed);
      issue({r[31:22], 2'b00, 5'd5, 15'b0}, OP0_ZERO, OP1_ZERO, ALU_ADD, PC_JUMPREG, LD_W,
            WB_EXE, '0, 1'b0, 5'd0);
      bubble();
      r = $random(seed) & ~32'h0020_0000;
      issue(r, OP0_ZERO, OP1_ZERO, ALU_ADD, PC_JUMP, LD_W, WB_EXE, '0, 1'b0, 5'd0);
      bubble();
    end

    // Loads of each width
    for (i = 0; i < 15; i++) begin
      r = $random(seed);
      issue('0, OP0_ZERO, OP1_ZERO, ALU_ADD, PC_PLUS4, load_sel_e'(i % 5), WB_MEM, r,
            1'b0, 5'd0);
    end

    repeat (4) bubble();

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/core_dpath.sv
// Scalar datapath top. The controller drives each select in its own stage.
// One stall level freezes all pipeline registers together.

`timescale 1ns/10ps
`default_nettype none

module core_dpath import dpath_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               stall,
  input  pc_sel_e            pc_sel,
  input  logic [XLEN-1:0]    inst_d,
  input  byp_sel_e           rdata0_byp_sel,
  input  byp_sel_e           rdata1_byp_sel,
  input  op0_sel_e           op0_sel,
  input  op1_sel_e           op1_sel,
  input  alu_fn_e            alu_fn,
  input  logic [XLEN-1:0]    dmem_rdata,
  input  load_sel_e          load_sel,
  input  wb_sel_e            wb_sel,
  input  logic               rf_wen,
  input  logic [RADDR_W-1:0] rf_waddr,
  output logic [XLEN-1:0]    imem_addr,
  output logic [XLEN-1:0]    dmem_addr,
  output logic [XLEN-1:0]    dmem_wdata,
  output logic               branch_cond_eq,
  output logic               branch_cond_ne,
  output logic               branch_cond_lt,
  output logic               branch_cond_ltu,
  output logic               branch_cond_ge,
  output logic               branch_cond_geu,
  output logic [XLEN-1:0]    wb_data
);

  logic [XLEN-1:0] pc_d, pc_plus4_d, jump_targ_d, jumpreg_targ_d;
  logic [XLEN-1:0] branch_targ_x, op0_x, op1_x, wdata_x, alu_out_x;
  logic [XLEN-1:0] exe_out_m, wb_m, wb_w;

  fetch_stage fetch (
    .clk, .reset, .stall, .pc_sel,
    .branch_targ_x, .jump_targ_d, .jumpreg_targ_d,
    .imem_addr, .pc_d, .pc_plus4_d
  );

  decode_stage decode (
    .clk, .reset, .stall, .inst_d, .pc_d, .pc_plus4_d,
    .rdata0_byp_sel, .rdata1_byp_sel, .op0_sel, .op1_sel,
    .alu_out_x, .wb_m, .wb_w, .rf_wen, .rf_waddr,
    .jump_targ_d, .jumpreg_targ_d, .branch_targ_x, .op0_x, .op1_x, .wdata_x
  );

  execute_stage execute (
    .clk, .stall, .alu_fn, .op0_x, .op1_x, .wdata_x,
    .alu_out_x, .dmem_addr, .dmem_wdata,
    .branch_cond_eq, .branch_cond_ne, .branch_cond_lt,
    .branch_cond_ltu, .branch_cond_ge, .branch_cond_geu,
    .exe_out_m
  );

  mem_wb_stage mem_wb (
    .clk, .stall, .exe_out_m, .dmem_rdata, .load_sel, .wb_sel,
    .wb_m, .wb_w
  );

  // Writeback value, also the CSR write data
  assign wb_data = wb_w;

endmodule

`default_nettype wire

// File: rtl/mem_wb_stage.sv
// Load extension, writeback select and the W register.
// dmem_rdata is expected in M, one cycle after the request.

`timescale 1ns/10ps
`default_nettype none

module mem_wb_stage import dpath_pkg::*; (
  input  logic            clk,
  input  logic            stall,
  input  logic [XLEN-1:0] exe_out_m,
  input  logic [XLEN-1:0] dmem_rdata,
  input  load_sel_e       load_sel,
  input  wb_sel_e         wb_sel,
  output logic [XLEN-1:0] wb_m,
  output logic [XLEN-1:0] wb_w
);

  logic [XLEN-1:0] load_val;

  // Sub-word data sits in the low bits of the response
  always_comb begin
    case (load_sel)
      LD_B:    load_val = {{(XLEN-8){dmem_rdata[7]}}, dmem_rdata[7:0]};
      LD_BU:   load_val = {{(XLEN-8){1'b0}}, dmem_rdata[7:0]};
      LD_H:    load_val = {{(XLEN-16){dmem_rdata[15]}}, dmem_rdata[15:0]};
      LD_HU:   load_val = {{(XLEN-16){1'b0}}, dmem_rdata[15:0]};
      default: load_val = dmem_rdata;
    endcase
  end

  assign wb_m = (wb_sel == WB_MEM) ? load_val : exe_out_m;

  // W <- M
  always_ff @(posedge clk) begin
    if (!stall) begin
      wb_w <= wb_m;
    end
  end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
// ALU, branch condition flags and the data memory request.
// Flags are valid for any alu_fn since they use their own subtraction.

`timescale 1ns/10ps
`default_nettype none

module execute_stage import dpath_pkg::*; (
  input  logic            clk,
  input  logic            stall,
  input  alu_fn_e         alu_fn,
  input  logic [XLEN-1:0] op0_x,
  input  logic [XLEN-1:0] op1_x,
  input  logic [XLEN-1:0] wdata_x,
  output logic [XLEN-1:0] alu_out_x,
  output logic [XLEN-1:0] dmem_addr,
  output logic [XLEN-1:0] dmem_wdata,
  output logic            branch_cond_eq,
  output logic            branch_cond_ne,
  output logic            branch_cond_lt,
  output logic            branch_cond_ltu,
  output logic            branch_cond_ge,
  output logic            branch_cond_geu,
  output logic [XLEN-1:0] exe_out_m
);

  logic [XLEN-1:0] diff_x;
  logic [4:0]      sh_amt;
  logic            diff_signs;

  assign diff_x = op0_x - op1_x;
  assign sh_amt = op1_x[4:0];

  // ----------------------------------------------------------
  // ALU
  // ----------------------------------------------------------

  always_comb begin
    case (alu_fn)
      ALU_ADD:    alu_out_x = op0_x + op1_x;
      ALU_SUB:    alu_out_x = diff_x;
      ALU_SLL:    alu_out_x = op0_x << sh_amt;
      ALU_SLT:    alu_out_x = XLEN'($signed(op0_x) < $signed(op1_x));
      ALU_SLTU:   alu_out_x = XLEN'(op0_x < op1_x);
      ALU_XOR:    alu_out_x = op0_x ^ op1_x;
      ALU_SRL:    alu_out_x = op0_x >> sh_amt;
      ALU_SRA:    alu_out_x = $unsigned($signed(op0_x) >>> sh_amt);
      ALU_OR:     alu_out_x = op0_x | op1_x;
      ALU_AND:    alu_out_x = op0_x & op1_x;
      ALU_CP_OP0: alu_out_x = op0_x;
      ALU_CP_OP1: alu_out_x = op1_x;
      default:    alu_out_x = '0;
    endcase
  end

  // ----------------------------------------------------------
  // Branch flags
  // ----------------------------------------------------------

  // When signs differ the difference may overflow, so the sign bits decide
  assign diff_signs      = op0_x[XLEN-1] ^ op1_x[XLEN-1];
  assign branch_cond_eq  = (diff_x == '0);
  assign branch_cond_ne  = !branch_cond_eq;
  assign branch_cond_lt  = diff_signs ? op0_x[XLEN-1] : diff_x[XLEN-1];
  assign branch_cond_ltu = diff_signs ? op1_x[XLEN-1] : diff_x[XLEN-1];
  assign branch_cond_ge  = diff_signs ? op1_x[XLEN-1] : !diff_x[XLEN-1];
  assign branch_cond_geu = diff_signs ? op0_x[XLEN-1] : !diff_x[XLEN-1];

  // Request leaves in X, response comes back in M
  assign dmem_addr  = alu_out_x;
  assign dmem_wdata = wdata_x;

  // M <- X
  always_ff @(posedge clk) begin
    if (!stall) begin
      exe_out_m <= alu_out_x;
    end
  end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
// Decode and register read with bypass from X, M and W.
// Bypass and operand selects come from the controller, which resolves hazards.

`timescale 1ns/10ps
`default_nettype none

module decode_stage import dpath_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               stall,
  input  logic [XLEN-1:0]    inst_d,
  input  logic [XLEN-1:0]    pc_d,
  input  logic [XLEN-1:0]    pc_plus4_d,
  input  byp_sel_e           rdata0_byp_sel,
  input  byp_sel_e           rdata1_byp_sel,
  input  op0_sel_e           op0_sel,
  input  op1_sel_e           op1_sel,
  input  logic [XLEN-1:0]    alu_out_x,
  input  logic [XLEN-1:0]    wb_m,
  input  logic [XLEN-1:0]    wb_w,
  input  logic               rf_wen,
  input  logic [RADDR_W-1:0] rf_waddr,
  output logic [XLEN-1:0]    jump_targ_d,
  output logic [XLEN-1:0]    jumpreg_targ_d,
  output logic [XLEN-1:0]    branch_targ_x,
  output logic [XLEN-1:0]    op0_x,
  output logic [XLEN-1:0]    op1_x,
  output logic [XLEN-1:0]    wdata_x
);

  // ----------------------------------------------------------
  // Instruction fields
  // ----------------------------------------------------------

  logic [RADDR_W-1:0] rs1, rs2;
  logic [XLEN-1:0]    shamt, imm_i, imm_s, imm_sb, imm_u, imm_uj;

  assign rs1    = inst_d[19:15];
  assign rs2    = inst_d[24:20];
  assign shamt  = {{(XLEN-5){1'b0}}, inst_d[24:20]};
  assign imm_i  = {{(XLEN-12){inst_d[31]}}, inst_d[31:20]};
  assign imm_s  = {{(XLEN-12){inst_d[31]}}, inst_d[31:25], inst_d[11:7]};
  assign imm_sb = {{(XLEN-12){inst_d[31]}}, inst_d[7], inst_d[30:25], inst_d[11:8], 1'b0};
  assign imm_u  = {inst_d[31:12], 12'b0};
  assign imm_uj = {{(XLEN-20){inst_d[31]}}, inst_d[19:12], inst_d[20], inst_d[30:21], 1'b0};

  // ----------------------------------------------------------
  // Register read and bypass
  // ----------------------------------------------------------

  logic [XLEN-1:0] rf_rdata0, rf_rdata1;
  logic [XLEN-1:0] rs1_val, rs2_val, jr_sum;

  regfile rfile (
    .clk    (clk),
    .raddr0 (rs1),
    .raddr1 (rs2),
    .waddr  (rf_waddr),
    .wen    (rf_wen),
    .wdata  (wb_w),
    .rdata0 (rf_rdata0),
    .rdata1 (rf_rdata1)
  );

  function automatic logic [XLEN-1:0] byp_pick(input byp_sel_e sel,
      input logic [XLEN-1:0] rf_val, input logic [XLEN-1:0] x_val,
      input logic [XLEN-1:0] m_val, input logic [XLEN-1:0] w_val);
    case (sel)
      BYP_X:   return x_val;
      BYP_M:   return m_val;
      BYP_W:   return w_val;
      default: return rf_val;
    endcase
  endfunction

  assign rs1_val = byp_pick(rdata0_byp_sel, rf_rdata0, alu_out_x, wb_m, wb_w);
  assign rs2_val = byp_pick(rdata1_byp_sel, rf_rdata1, alu_out_x, wb_m, wb_w);

  // Jump targets feed the PC mux in this same cycle
  assign jump_targ_d    = pc_d + imm_uj;
  assign jr_sum         = rs1_val + imm_i;
  assign jumpreg_targ_d = {jr_sum[XLEN-1:1], 1'b0};

  // ----------------------------------------------------------
  // Operand muxes and X <- D
  // ----------------------------------------------------------

  logic [XLEN-1:0] op0_d, op1_d;

  always_comb begin
    case (op0_sel)
      OP0_PC:       op0_d = pc_d;
      OP0_PC_PLUS4: op0_d = pc_plus4_d;
      OP0_ZERO:     op0_d = '0;
      default:      op0_d = rs1_val;
    endcase
  end

  always_comb begin
    case (op1_sel)
      OP1_SHAMT:  op1_d = shamt;
      OP1_IMM_U:  op1_d = imm_u;
      OP1_IMM_SB: op1_d = imm_sb;
      OP1_IMM_I:  op1_d = imm_i;
      OP1_IMM_S:  op1_d = imm_s;
      OP1_ZERO:   op1_d = '0;
      default:    op1_d = rs2_val;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      branch_targ_x <= pc_d + imm_sb;
      op0_x         <= op0_d;
      op1_x         <= op1_d;
      wdata_x       <= rs2_val;
    end
  end

  byp_sel_known: assert property (@(posedge clk) disable iff (reset)
      !$isunknown({rdata0_byp_sel, rdata1_byp_sel}))
    else $error("bypass select unknown in decode");

endmodule

`default_nettype wire

// File: rtl/regfile.sv
// 32 x 32 register file, two async read ports, one sync write port.
// x0 reads zero. A read in the write cycle returns the old value.

`timescale 1ns/10ps
`default_nettype none

module regfile import dpath_pkg::*; (
  input  logic               clk,
  input  logic [RADDR_W-1:0] raddr0,
  input  logic [RADDR_W-1:0] raddr1,
  input  logic [RADDR_W-1:0] waddr,
  input  logic               wen,
  input  logic [XLEN-1:0]    wdata,
  output logic [XLEN-1:0]    rdata0,
  output logic [XLEN-1:0]    rdata1
);

  logic [XLEN-1:0] regs [NREGS];

  always_ff @(posedge clk) begin
    if (wen) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 is hardwired regardless of what was written
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

  wen_addr_known: assert property (@(posedge clk) wen |-> !$isunknown(waddr))
    else $error("register write with unknown address");

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
// PC select and fetch. Only the PC register is reset.
// Branch target arrives from X, jump targets from D, in the same cycle.

`timescale 1ns/10ps
`default_nettype none

module fetch_stage import dpath_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            stall,
  input  pc_sel_e         pc_sel,
  input  logic [XLEN-1:0] branch_targ_x,
  input  logic [XLEN-1:0] jump_targ_d,
  input  logic [XLEN-1:0] jumpreg_targ_d,
  output logic [XLEN-1:0] imem_addr,
  output logic [XLEN-1:0] pc_d,
  output logic [XLEN-1:0] pc_plus4_d
);

  logic [XLEN-1:0] pc_f;
  logic [XLEN-1:0] pc_plus4_f;
  logic [XLEN-1:0] pc_next;

  assign pc_plus4_f = pc_f + XLEN'(4);

  always_comb begin
    case (pc_sel)
      PC_BRANCH:  pc_next = branch_targ_x;
      PC_JUMP:    pc_next = jump_targ_d;
      PC_JUMPREG: pc_next = jumpreg_targ_d;
      default:    pc_next = pc_plus4_f;
    endcase
  end

  // Request goes out in the same cycle the next PC is chosen
  assign imem_addr = reset ? RESET_VECTOR : pc_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= RESET_VECTOR;
    end else if (!stall) begin
      pc_f <= pc_next;
    end
  end

  // D <- F
  always_ff @(posedge clk) begin
    if (!stall) begin
      pc_d       <= pc_f;
      pc_plus4_d <= pc_plus4_f;
    end
  end

  // Targets from D and X must keep the fetch address on a word boundary
  pc_aligned: assert property (@(posedge clk) disable iff (reset) pc_f[1:0] == 2'b00)
    else $error("fetch PC not word aligned: %h", pc_f);

endmodule

`default_nettype wire

// File: rtl/dpath_pkg.sv
// Widths, reset vector and select encodings shared by every stage.
// Select encodings follow the order in which the controller drives them.

`default_nettype none

package dpath_pkg;

  localparam int XLEN    = 32;
  localparam int NREGS   = 32;
  localparam int RADDR_W = 5;

  // First fetch address after reset
  localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0008_0000;

  // ----------------------------------------------------------
  // Select and opcode encodings
  // ----------------------------------------------------------

  typedef enum logic [1:0] {
    PC_PLUS4, PC_BRANCH, PC_JUMP, PC_JUMPREG
  } pc_sel_e;

  typedef enum logic [1:0] {
    OP0_RS1, OP0_PC, OP0_PC_PLUS4, OP0_ZERO
  } op0_sel_e;

  typedef enum logic [2:0] {
    OP1_RS2, OP1_SHAMT, OP1_IMM_U, OP1_IMM_SB, OP1_IMM_I, OP1_IMM_S, OP1_ZERO
  } op1_sel_e;

  // Register file, or the value about to leave X, M or W
  typedef enum logic [1:0] {
    BYP_RF, BYP_X, BYP_M, BYP_W
  } byp_sel_e;

  // Shifts take the low 5 bits of op1; SLT and SLTU give 1 or 0
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_CP_OP0, ALU_CP_OP1
  } alu_fn_e;

  typedef enum logic [2:0] {
    LD_W, LD_B, LD_BU, LD_H, LD_HU
  } load_sel_e;

  typedef enum logic [0:0] {
    WB_EXE, WB_MEM
  } wb_sel_e;

endpackage

`default_nettype wire
